/* hdl/membus_pkg.sv */
package membus_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////////////////////////

	localparam int addr_w = 18;
	localparam int word_w = 16;

	// CPU and SRAM address
	typedef logic [addr_w-1:0] addr_t;

	// Shared data bus word
	typedef logic [word_w-1:0] word_t;

	//////////////////////////////////////////////////////////////////////
	// Request kinds
	//////////////////////////////////////////////////////////////////////

	// One entry per bus operation the sequencer can run for the CPU
	typedef enum logic [2:0] {
		kind_ram_rd,
		kind_ram_wr,
		kind_uart_tx,
		kind_uart_pop,
		kind_uart_stat
	} req_kind_t;

	//////////////////////////////////////////////////////////////////////
	// Address map and status layout
	//////////////////////////////////////////////////////////////////////

	// UART data port, write sends and read pops the queue
	localparam addr_t uart_data_addr = 18'h0BF00;
	localparam addr_t uart_stat_addr = 18'h0BF01;

	// Status word bits
	localparam int stat_rx_bit   = 0;
	localparam int stat_tbre_bit = 1;

endpackage

/* hdl/mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if;

	// Request side, valid together with the req strobe
	logic                   req;
	membus_pkg::req_kind_t  kind;
	membus_pkg::addr_t      addr;
	membus_pkg::word_t      wdata;

	// Completion side
	logic                   done;
	membus_pkg::word_t      rdata;

	modport decoder (
		output req,
		output kind,
		output addr,
		output wdata,
		input  done,
		input  rdata
	);

	modport sequencer (
		input  req,
		input  kind,
		input  addr,
		input  wdata,
		output done,
		output rdata
	);

endinterface

/* hdl/req_decode.sv */
`timescale 1ns/1ps

module req_decode (
	input  logic                clk,
	input  logic                rst,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  logic                mem_act,
	input  membus_pkg::addr_t   mem_addr,
	input  membus_pkg::word_t   mem_wdata,
	output logic                mem_done,
	output logic                mem_act_out,
	output membus_pkg::word_t   mem_rdata,
	mem_req_if.decoder          bus
);

	logic                   busy;
	logic                   new_req;
	membus_pkg::req_kind_t  kind_d;

	// New request when the token moved and nothing is in flight
	assign new_req = (mem_rd || mem_wr) && (mem_act != mem_act_out) && !busy;

	//////////////////////////////////////////////////////////////////////
	// Target decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (mem_addr == membus_pkg::uart_data_addr) begin
			if (mem_wr)
				kind_d = membus_pkg::kind_uart_tx;
			else
				kind_d = membus_pkg::kind_uart_pop;
		end else if (mem_addr == membus_pkg::uart_stat_addr) begin
			// Writes to the status port are treated as reads
			kind_d = membus_pkg::kind_uart_stat;
		end else if (mem_wr) begin
			kind_d = membus_pkg::kind_ram_wr;
		end else begin
			kind_d = membus_pkg::kind_ram_rd;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Token, busy and done flag
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			bus.req     <= 1'b0;
			busy        <= 1'b0;
			mem_done    <= 1'b0;
			mem_act_out <= 1'b0;
		end else begin
			bus.req <= new_req;
			if (new_req) begin
				busy     <= 1'b1;
				mem_done <= 1'b0;
			end else if (bus.done) begin
				busy        <= 1'b0;
				mem_done    <= 1'b1;
				// Hand the token back to the CPU
				mem_act_out <= mem_act;
			end
		end
	end

	// Request payload and returned data
	always_ff @(posedge clk) begin
		if (new_req) begin
			bus.kind  <= kind_d;
			bus.addr  <= mem_addr;
			bus.wdata <= mem_wdata;
		end
		if (bus.done)
			mem_rdata <= bus.rdata;
	end

endmodule

/* hdl/rx_queue.sv */
`timescale 1ns/1ps

module rx_queue #(
	parameter int queue_log2 = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                push,
	input  membus_pkg::word_t   push_data,
	input  logic                pop,
	output membus_pkg::word_t   front_data,
	output logic                empty,
	output logic                full
);

	localparam int depth = 1 << queue_log2;

	membus_pkg::word_t  mem [depth];

	// One extra bit tells a full queue from an empty one
	logic [queue_log2:0]  front_ptr;
	logic [queue_log2:0]  tail_ptr;
	logic                 do_push;
	logic                 do_pop;

	assign empty = (front_ptr == tail_ptr);
	assign full  = (front_ptr[queue_log2] != tail_ptr[queue_log2]) &&
		(front_ptr[queue_log2-1:0] == tail_ptr[queue_log2-1:0]);

	// Overflow and underflow are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign front_data = mem[front_ptr[queue_log2-1:0]];

	//////////////////////////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			front_ptr <= '0;
			tail_ptr  <= '0;
		end else begin
			if (do_push)
				tail_ptr <= tail_ptr + 1'b1;
			if (do_pop)
				front_ptr <= front_ptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[tail_ptr[queue_log2-1:0]] <= push_data;
	end

endmodule

/* hdl/bus_sequencer.sv */
`timescale 1ns/1ps

module bus_sequencer #(
	parameter int queue_log2 = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  membus_pkg::word_t   ram_rdata,
	input  logic                uart_data_ready,
	input  logic                uart_tbre,
	input  logic                uart_tsre,
	input  membus_pkg::word_t   front_data,
	input  logic                empty,
	input  logic                full,
	output membus_pkg::addr_t   ram_addr,
	output membus_pkg::word_t   ram_wdata,
	output logic                ram_data_oe,
	output logic                ram_en,
	output logic                ram_oe,
	output logic                ram_we,
	output logic                uart_rdn,
	output logic                uart_wrn,
	output logic                push,
	output membus_pkg::word_t   push_data,
	output logic                pop,
	mem_req_if.sequencer        bus
);

	// Queue must hold at least two words
	if (queue_log2 < 1) begin : g_depth_check
		$error("queue_log2 must be at least 1");
	end

	typedef enum logic [3:0] {
		st_idle,
		st_rx1, st_rx2, st_rx3,
		st_rd1, st_rd2, st_rd3,
		st_wr1, st_wr2, st_wr3,
		st_tx1, st_tx2, st_tx3, st_tx4,
		st_pop, st_stat
	} state_t;

	state_t                 state;
	state_t                 next_state;
	logic                   pend_valid;
	logic                   rx_start;
	logic                   start_valid;
	membus_pkg::req_kind_t  start_kind;
	membus_pkg::req_kind_t  op_kind;
	membus_pkg::addr_t      op_addr;
	membus_pkg::word_t      op_wdata;
	membus_pkg::word_t      rdata_q;
	membus_pkg::word_t      stat_word;

	// Receive has priority over a CPU request
	assign rx_start    = uart_data_ready && !full;
	assign start_valid = bus.req || pend_valid;
	assign start_kind  = bus.req ? bus.kind : op_kind;

	//////////////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (rx_start) begin
					next_state = st_rx1;
				end else if (start_valid) begin
					case (start_kind)
						membus_pkg::kind_ram_rd:  next_state = st_rd1;
						membus_pkg::kind_ram_wr:  next_state = st_wr1;
						membus_pkg::kind_uart_tx: next_state = st_tx1;
						membus_pkg::kind_uart_pop: next_state = st_pop;
						default:                  next_state = st_stat;
					endcase
				end
			end
			st_rx1: next_state = st_rx2;
			st_rx2: next_state = st_rx3;
			st_rd1: next_state = st_rd2;
			st_rd2: next_state = st_rd3;
			st_wr1: next_state = st_wr2;
			st_wr2: next_state = st_wr3;
			st_tx1: next_state = st_tx2;
			// Hold the write strobe until the UART takes the byte
			st_tx2: if (!uart_tbre) next_state = st_tx3;
			st_tx3: if (uart_tbre) next_state = st_tx4;
			st_tx4: if (uart_tsre) next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state      <= st_idle;
			pend_valid <= 1'b0;
		end else begin
			state <= next_state;
			// Idle without a receive always dispatches what is waiting
			if (state == st_idle && !rx_start)
				pend_valid <= 1'b0;
			else if (bus.req)
				pend_valid <= 1'b1;
		end
	end

	// Request payload and SRAM read data
	always_ff @(posedge clk) begin
		if (bus.req) begin
			op_kind  <= bus.kind;
			op_addr  <= bus.addr;
			op_wdata <= bus.wdata;
		end
		if (state == st_rd2)
			rdata_q <= ram_rdata;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus strobes
	//////////////////////////////////////////////////////////////////////

	assign ram_addr  = op_addr;
	assign ram_wdata = op_wdata;

	assign ram_en = !(state inside {st_rd1, st_rd2, st_wr1, st_wr2, st_wr3});
	assign ram_oe = !(state == st_rd2);
	assign ram_we = !(state == st_wr2);

	// CPU drives the bus for SRAM writes and the whole transmit
	assign ram_data_oe = state inside {st_wr1, st_wr2, st_wr3,
		st_tx1, st_tx2, st_tx3, st_tx4};

	assign uart_rdn = !(state inside {st_rx1, st_rx2});
	assign uart_wrn = !(state == st_tx2);

	// Receive word goes straight from the bus into the queue
	assign push      = (state == st_rx2);
	assign push_data = ram_rdata;
	assign pop       = (state == st_pop) && !empty;

	always_comb begin
		stat_word = '0;
		stat_word[membus_pkg::stat_rx_bit]   = !empty;
		stat_word[membus_pkg::stat_tbre_bit] = uart_tbre;
	end

	// Completion
	assign bus.done = (state inside {st_rd3, st_wr3, st_pop, st_stat}) ||
		(state == st_tx4 && uart_tsre);

	always_comb begin
		case (state)
			st_pop:  bus.rdata = empty ? '0 : front_data;
			st_stat: bus.rdata = stat_word;
			default: bus.rdata = rdata_q;
		endcase
	end

endmodule

/* hdl/membus_top.sv */
`timescale 1ns/1ps

module membus_top #(
	parameter int queue_log2 = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  logic                mem_act,
	input  membus_pkg::addr_t   mem_addr,
	input  membus_pkg::word_t   mem_wdata,
	input  membus_pkg::word_t   ram_rdata,
	input  logic                uart_data_ready,
	input  logic                uart_tbre,
	input  logic                uart_tsre,
	output logic                mem_done,
	output logic                mem_act_out,
	output membus_pkg::word_t   mem_rdata,
	output membus_pkg::addr_t   ram_addr,
	output membus_pkg::word_t   ram_wdata,
	output logic                ram_data_oe,
	output logic                ram_en,
	output logic                ram_oe,
	output logic                ram_we,
	output logic                uart_rdn,
	output logic                uart_wrn
);

	// Receive queue link
	logic               push;
	membus_pkg::word_t  push_data;
	logic               pop;
	membus_pkg::word_t  front_data;
	logic               empty;
	logic               full;

	mem_req_if u_req_if ();

	req_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.mem_rd      (mem_rd),
		.mem_wr      (mem_wr),
		.mem_act     (mem_act),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_done    (mem_done),
		.mem_act_out (mem_act_out),
		.mem_rdata   (mem_rdata),
		.bus         (u_req_if.decoder)
	);

	bus_sequencer #(
		.queue_log2 (queue_log2)
	) u_sequencer (
		.clk             (clk),
		.rst             (rst),
		.ram_rdata       (ram_rdata),
		.uart_data_ready (uart_data_ready),
		.uart_tbre       (uart_tbre),
		.uart_tsre       (uart_tsre),
		.front_data      (front_data),
		.empty           (empty),
		.full            (full),
		.ram_addr        (ram_addr),
		.ram_wdata       (ram_wdata),
		.ram_data_oe     (ram_data_oe),
		.ram_en          (ram_en),
		.ram_oe          (ram_oe),
		.ram_we          (ram_we),
		.uart_rdn        (uart_rdn),
		.uart_wrn        (uart_wrn),
		.push            (push),
		.push_data       (push_data),
		.pop             (pop),
		.bus             (u_req_if.sequencer)
	);

	rx_queue #(
		.queue_log2 (queue_log2)
	) u_rx_queue (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_data  (push_data),
		.pop        (pop),
		.front_data (front_data),
		.empty      (empty),
		.full       (full)
	);

endmodule

/* bench/membus_properties.sv */
`timescale 1ns/1ps

module membus_properties (
	input  logic  clk,
	input  logic  rst,
	input  logic  req,
	input  logic  done,
	input  logic  ram_data_oe,
	input  logic  ram_en,
	input  logic  ram_oe,
	input  logic  ram_we,
	input  logic  uart_rdn,
	input  logic  uart_wrn
);

	int    wait_cnt;
	logic  in_tx;

	// Transmit is the only state that drives the bus with the SRAM disabled
	assign in_tx = ram_data_oe && ram_en;

	// Cycles since the last req without a done
	always_ff @(posedge clk) begin
		if (!rst)
			wait_cnt <= 0;
		else if (done || in_tx)
			wait_cnt <= 0;
		else if (req || wait_cnt != 0)
			wait_cnt <= wait_cnt + 1;
	end

	assert property (@(posedge clk) disable iff (!rst) ram_oe || ram_we)
		else $error("ram_oe and ram_we low in the same cycle");
	assert property (@(posedge clk) disable iff (!rst) uart_rdn || uart_wrn)
		else $error("uart_rdn and uart_wrn low in the same cycle");
	assert property (@(posedge clk) disable iff (!rst) !(ram_data_oe && (!ram_oe || !uart_rdn)))
		else $error("bus driven while the SRAM or UART drives it");
	assert property (@(posedge clk) disable iff (!rst) wait_cnt < 64)
		else $error("request not completed within 64 cycles");

endmodule

bind bus_sequencer membus_properties u_props (
	.clk         (clk),
	.rst         (rst),
	.req         (bus.req),
	.done        (bus.done),
	.ram_data_oe (ram_data_oe),
	.ram_en      (ram_en),
	.ram_oe      (ram_oe),
	.ram_we      (ram_we),
	.uart_rdn    (uart_rdn),
	.uart_wrn    (uart_wrn)
);

/* bench/membus_tb.sv */
`timescale 1ns/1ps

module membus_tb;

	localparam int queue_log2     = 2;
	localparam int depth          = 1 << queue_log2;
	localparam int timeout_cycles = 200;

	logic               clk;
	logic               rst;
	logic               mem_rd, mem_wr, mem_act;
	membus_pkg::addr_t  mem_addr;
	membus_pkg::word_t  mem_wdata;
	membus_pkg::word_t  ram_rdata;
	logic               uart_data_ready, uart_tbre, uart_tsre;
	logic               mem_done, mem_act_out;
	membus_pkg::word_t  mem_rdata;
	membus_pkg::addr_t  ram_addr;
	membus_pkg::word_t  ram_wdata;
	logic               ram_data_oe, ram_en, ram_oe, ram_we, uart_rdn, uart_wrn;

	// SRAM contents, expected RAM values and the UART host side
	membus_pkg::word_t  sram [membus_pkg::addr_t];
	membus_pkg::word_t  shadow [membus_pkg::addr_t];
	membus_pkg::word_t  rx_list [$];
	membus_pkg::word_t  tx_log [$];
	int                 rx_sent;
	int                 rx_taken;
	int                 tbre_cnt;
	logic               rd_active;

	membus_top #(.queue_log2(queue_log2)) u_dut (.*);

	assign uart_data_ready = (rx_sent != rx_taken);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// SRAM and UART chip models
	//////////////////////////////////////////////////////////////////////

	initial begin
		ram_rdata = '0;
		uart_tbre = 1'b1;
		uart_tsre = 1'b1;
		rx_taken  = 0;
		tbre_cnt  = 0;
		rd_active = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			// Transmit completion must wait for the shift register to drain
			if (mem_done && !uart_tsre)
				fail_run("mem_done came before uart_tsre went high on a transmit");
			if (!ram_en && !ram_we)
				sram[ram_addr] = ram_wdata;
			if (!uart_rdn) begin
				ram_rdata = rx_list[rx_taken];
				rd_active = 1'b1;
			end else begin
				// Read strobe released so the word is consumed
				if (rd_active) begin
					rx_taken++;
					rd_active = 1'b0;
				end
				if (!ram_en && !ram_oe)
					ram_rdata = sram.exists(ram_addr) ? sram[ram_addr] : '0;
			end
			// Transmitter takes the byte, then drains
			if (!uart_wrn && uart_tbre) begin
				tx_log.push_back(ram_wdata);
				uart_tbre = 1'b0;
				uart_tsre = 1'b0;
				tbre_cnt  = $urandom_range(4, 1);
			end else if (!uart_tbre) begin
				tbre_cnt--;
				if (tbre_cnt == 0)
					uart_tbre = 1'b1;
			end else if (!uart_tsre) begin
				uart_tsre = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	function automatic logic [31:0] stat_value(input logic rx_ready, input logic tbre);
		logic [31:0] v;
		v = '0;
		v[membus_pkg::stat_rx_bit]   = rx_ready;
		v[membus_pkg::stat_tbre_bit] = tbre;
		return v;
	endfunction

	// One CPU access that toggles the token and waits for it to come back
	task automatic cpu_access(input logic wr, input membus_pkg::addr_t addr,
		input membus_pkg::word_t wdata, output membus_pkg::word_t rdata);
		int cycles;
		mem_rd    = !wr;
		mem_wr    = wr;
		mem_addr  = addr;
		mem_wdata = wdata;
		mem_act   = !mem_act;
		cycles    = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > timeout_cycles)
				fail_run("timeout waiting for mem_done on a CPU access");
		end while (!(mem_done && mem_act_out == mem_act));
		rdata = mem_rdata;
	endtask

	task automatic inject_rx(input membus_pkg::word_t w);
		rx_list.push_back(w);
		rx_sent++;
	endtask

	task automatic wait_rx_level(input int pending);
		int cycles;
		cycles = 0;
		while (rx_sent - rx_taken != pending) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > timeout_cycles)
				fail_run("timeout waiting for the UART model to hand over its words");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic ram_write_readback();
		membus_pkg::addr_t a;
		membus_pkg::word_t d;
		membus_pkg::word_t got;
		for (int i = 0; i < 40; i++) begin
			a = 18'h00400 + 18'($urandom_range(15, 0));
			if ($urandom_range(1, 0) == 0 || !shadow.exists(a)) begin
				d = 16'($urandom);
				shadow[a] = d;
				cpu_access(1'b1, a, d, got);
			end else begin
				cpu_access(1'b0, a, '0, got);
				check("mem_rdata", 32'(got), 32'(shadow[a]));
			end
		end
	endtask

	task automatic stale_token();
		membus_pkg::word_t got;
		cpu_access(1'b1, 18'h00500, 16'h1234, got);
		// Token unchanged so the new data must be ignored
		mem_addr  = 18'h00500;
		mem_wdata = 16'hdead;
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			#1;
			check("ram_en", 32'(ram_en), 32'h1);
			check("uart_rdn", 32'(uart_rdn), 32'h1);
			check("uart_wrn", 32'(uart_wrn), 32'h1);
			check("mem_done", 32'(mem_done), 32'h1);
		end
		cpu_access(1'b0, 18'h00500, '0, got);
		check("mem_rdata", 32'(got), 32'h1234);
	endtask

	task automatic uart_transmit_order();
		membus_pkg::word_t sent [$];
		membus_pkg::word_t d;
		membus_pkg::word_t got;
		int base;
		base = tx_log.size();
		for (int i = 0; i < 5; i++) begin
			d = 16'($urandom_range(255, 0));
			sent.push_back(d);
			cpu_access(1'b1, membus_pkg::uart_data_addr, d, got);
			check("tx_count", 32'(tx_log.size() - base), 32'(i + 1));
		end
		for (int i = 0; i < 5; i++)
			check("ram_wdata", 32'(tx_log[base + i]), 32'(sent[i]));
	endtask

	task automatic status_shows_tbre();
		membus_pkg::word_t got;
		int cycles;
		// UART still busy with a character of its own
		tbre_cnt  = 20;
		uart_tbre = 1'b0;
		cpu_access(1'b0, membus_pkg::uart_stat_addr, '0, got);
		check("status", 32'(got), stat_value(1'b0, 1'b0));
		cycles = 0;
		while (!uart_tbre) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > timeout_cycles)
				fail_run("timeout waiting for uart_tbre to return high");
		end
	endtask

	// Fills past the queue depth when extra is above zero
	task automatic uart_receive_order(input int extra);
		membus_pkg::word_t exp [$];
		membus_pkg::word_t got;
		int total;
		total = (extra > 0) ? depth + extra : 3;
		cpu_access(1'b0, membus_pkg::uart_stat_addr, '0, got);
		check("status", 32'(got), stat_value(1'b0, 1'b1));
		for (int i = 0; i < total; i++) begin
			exp.push_back(16'($urandom));
			inject_rx(exp[i]);
		end
		wait_rx_level(extra);
		repeat (10) @(posedge clk);
		#1;
		check("rx_pending", 32'(rx_sent - rx_taken), 32'(extra));
		cpu_access(1'b0, membus_pkg::uart_stat_addr, '0, got);
		check("status", 32'(got), stat_value(1'b1, 1'b1));
		for (int i = 0; i < total; i++) begin
			cpu_access(1'b0, membus_pkg::uart_data_addr, '0, got);
			check("mem_rdata", 32'(got), 32'(exp[i]));
		end
		cpu_access(1'b0, membus_pkg::uart_data_addr, '0, got);
		check("mem_rdata", 32'(got), 32'h0);
	endtask

	task automatic rx_during_ram();
		membus_pkg::word_t w0;
		membus_pkg::word_t w1;
		membus_pkg::word_t got;
		w0 = 16'($urandom);
		w1 = 16'($urandom);
		inject_rx(w0);
		cpu_access(1'b1, 18'h00600, 16'hbeef, got);
		inject_rx(w1);
		cpu_access(1'b0, 18'h00600, '0, got);
		check("mem_rdata", 32'(got), 32'hbeef);
		cpu_access(1'b0, membus_pkg::uart_data_addr, '0, got);
		check("mem_rdata", 32'(got), 32'(w0));
		cpu_access(1'b0, membus_pkg::uart_data_addr, '0, got);
		check("mem_rdata", 32'(got), 32'(w1));
	endtask

	initial begin
		void'($urandom(32'h9c5a_7131));
		rst       = 1'b0;
		mem_rd    = 1'b0;
		mem_wr    = 1'b0;
		mem_act   = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		rx_sent   = 0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b1;
		check("mem_done", 32'(mem_done), 32'h0);
		check("mem_act_out", 32'(mem_act_out), 32'h0);
		check("ram_data_oe", 32'(ram_data_oe), 32'h0);
		check("ram_en", 32'(ram_en), 32'h1);
		check("ram_oe", 32'(ram_oe), 32'h1);
		check("ram_we", 32'(ram_we), 32'h1);
		check("uart_rdn", 32'(uart_rdn), 32'h1);
		check("uart_wrn", 32'(uart_wrn), 32'h1);
		ram_write_readback();
		stale_token();
		uart_transmit_order();
		status_shows_tbre();
		uart_receive_order(0);
		uart_receive_order(3);
		rx_during_ram();
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* membus.f */
hdl/membus_pkg.sv
hdl/mem_req_if.sv
hdl/req_decode.sv
hdl/rx_queue.sv
hdl/bus_sequencer.sv
hdl/membus_top.sv
bench/membus_properties.sv
bench/membus_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' membus.f)

obj_dir/Vmembus_tb: membus.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module membus_tb -f membus.f

run: obj_dir/Vmembus_tb
	obj_dir/Vmembus_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
